// ==== sources.f ====
rtl/axi_pkg.sv
rtl/reset_sync.sv
rtl/read_arbiter.sv
rtl/burst_counter.sv
rtl/sram_wrapper.sv
rtl/axi_bus.sv
rtl/axi_mem_top.sv
dv/clk_gen.sv
dv/tb_axi_mem_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_axi_mem_top -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q '\*\*\* TEST FAILED \*\*\*' "$log"; then
  echo "Simulation reported a failure, see $log"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== dv/tb_axi_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem_top;

  import axi_pkg::*;

  localparam int num_rows = 20;
  localparam int reset_cycles = 8;

  typedef struct packed {
    logic master;
    logic write;
    logic [axi_addr_bits-1:0] addr;
    logic [axi_len_bits-1:0] len;
    logic [axi_strb_bits-1:0] strb;
    logic [axi_id_bits-1:0] id;
    logic pair;
  } row_t;

  logic clk, arst_n;
  logic [axi_id_bits-1:0] ar_id_m0, r_id_m0, ar_id_m1, aw_id_m1, r_id_m1, b_id_m1;
  logic [axi_addr_bits-1:0] ar_addr_m0, ar_addr_m1, aw_addr_m1;
  logic [axi_len_bits-1:0] ar_len_m0, ar_len_m1, aw_len_m1;
  logic [axi_size_bits-1:0] ar_size_m0, ar_size_m1, aw_size_m1;
  logic [1:0] ar_burst_m0, ar_burst_m1, aw_burst_m1, r_resp_m0, r_resp_m1, b_resp_m1;
  logic [axi_data_bits-1:0] r_data_m0, r_data_m1, w_data_m1;
  logic [axi_strb_bits-1:0] w_strb_m1;
  logic ar_valid_m0, r_ready_m0, ar_ready_m0, r_last_m0, r_valid_m0;
  logic ar_valid_m1, r_ready_m1, aw_valid_m1, w_last_m1, w_valid_m1, b_ready_m1;
  logic ar_ready_m1, r_last_m1, r_valid_m1, aw_ready_m1, w_ready_m1, b_valid_m1;

  row_t rows [num_rows];
  // Expected contents, indexed by address bit 16 then word index
  logic [axi_data_bits-1:0] ref_mem [2][sram_words];
  logic [31:0] lcg_state [2];
  // Cycle of the latest AR handshake per master
  int ar_cycle_of [2];
  logic prio_m1;
  int cycle_count = 0;
  int r;

  clk_gen u_clk_gen (.clk(clk));

  axi_mem_top u_axi_mem_top (.*);

  always @(negedge clk) cycle_count <= cycle_count + 1;

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic idle_outputs_low();
    check_value("ar_ready_m0", ar_ready_m0, 0);
    check_value("r_valid_m0", r_valid_m0, 0);
    check_value("ar_ready_m1", ar_ready_m1, 0);
    check_value("r_valid_m1", r_valid_m1, 0);
    check_value("aw_ready_m1", aw_ready_m1, 0);
    check_value("w_ready_m1", w_ready_m1, 0);
    check_value("b_valid_m1", b_valid_m1, 0);
  endtask

  task automatic drive_ar(input logic m, input row_t row, input logic valid);
    if (m) begin
      {ar_id_m1, ar_addr_m1, ar_len_m1} = {row.id, row.addr, row.len};
      {ar_size_m1, ar_burst_m1, ar_valid_m1} = {size_word, burst_incr, valid};
    end else begin
      {ar_id_m0, ar_addr_m0, ar_len_m0} = {row.id, row.addr, row.len};
      {ar_size_m0, ar_burst_m0, ar_valid_m0} = {size_word, burst_incr, valid};
    end
  endtask

  // Roughly one cycle in four stalls
  task automatic pick_r_ready(input logic m, input logic en);
    lcg_state[m] = lcg_step(lcg_state[m]);
    if (m) r_ready_m1 = en && (lcg_state[1][17:16] != 2'b00);
    else r_ready_m0 = en && (lcg_state[0][17:16] != 2'b00);
  endtask

  task automatic write_burst(input row_t row);
    int beat;
    int b;
    logic [sram_index_bits-1:0] idx;
    @(negedge clk);
    {aw_id_m1, aw_addr_m1, aw_len_m1} = {row.id, row.addr, row.len};
    {aw_size_m1, aw_burst_m1, aw_valid_m1} = {size_word, burst_incr, 1'b1};
    #1;
    while (!aw_ready_m1) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    aw_valid_m1 = 1'b0;
    for (beat = 0; beat <= int'(row.len); beat++) begin
      lcg_state[1] = lcg_step(lcg_state[1]);
      w_data_m1 = lcg_state[1];
      w_strb_m1 = row.strb;
      w_last_m1 = (beat == int'(row.len));
      w_valid_m1 = 1'b1;
      #1;
      while (!w_ready_m1) begin
        @(negedge clk);
        #1;
      end
      idx = row.addr[11:2] + 10'(beat);
      for (b = 0; b < axi_strb_bits; b++) begin
        if (row.strb[b]) ref_mem[row.addr[16]][idx][8*b +: 8] = w_data_m1[8*b +: 8];
      end
      @(negedge clk);
    end
    {w_valid_m1, w_last_m1} = 2'b00;
    lcg_state[1] = lcg_step(lcg_state[1]);
    b_ready_m1 = (lcg_state[1][17:16] != 2'b00);
    #1;
    while (!(b_valid_m1 && b_ready_m1)) begin
      @(negedge clk);
      lcg_state[1] = lcg_step(lcg_state[1]);
      b_ready_m1 = (lcg_state[1][17:16] != 2'b00);
      #1;
    end
    check_value("b_id_m1", b_id_m1, row.id);
    check_value("b_resp_m1", b_resp_m1, 2'b00);
    @(negedge clk);
    b_ready_m1 = 1'b0;
  endtask

  task automatic read_burst(input row_t row);
    int beat;
    logic m, ar_done, r_lst;
    logic [sram_index_bits-1:0] idx;
    logic [axi_id_bits-1:0] rid;
    logic [1:0] rresp;
    logic [axi_data_bits-1:0] rdata;
    m = row.master;
    beat = 0;
    ar_done = 1'b0;
    @(negedge clk);
    drive_ar(m, row, 1'b1);
    pick_r_ready(m, 1'b1);
    while (beat <= int'(row.len)) begin
      #1;
      if (!ar_done && (m ? ar_ready_m1 : ar_ready_m0)) begin
        ar_done = 1'b1;
        ar_cycle_of[m] = cycle_count;
      end
      if (m ? (r_valid_m1 && r_ready_m1) : (r_valid_m0 && r_ready_m0)) begin
        rdata = m ? r_data_m1 : r_data_m0;
        rid = m ? r_id_m1 : r_id_m0;
        rresp = m ? r_resp_m1 : r_resp_m0;
        r_lst = m ? r_last_m1 : r_last_m0;
        idx = row.addr[11:2] + 10'(beat);
        check_value($sformatf("r_data_m%0d", m), rdata, ref_mem[row.addr[16]][idx]);
        check_value($sformatf("r_id_m%0d", m), rid, row.id);
        check_value($sformatf("r_resp_m%0d", m), rresp, 2'b00);
        check_value($sformatf("r_last_m%0d", m), r_lst, beat == int'(row.len));
        beat++;
      end
      @(negedge clk);
      if (ar_done) drive_ar(m, row, 1'b0);
      pick_r_ready(m, 1'b1);
    end
    pick_r_ready(m, 1'b0);
  endtask

  // Both masters raise ar_valid on the same edge
  task automatic read_collision(input int idx);
    logic got_first, exp_first;
    exp_first = prio_m1;
    fork
      read_burst(rows[idx]);
      read_burst(rows[idx+1]);
    join
    if (ar_cycle_of[rows[idx].master] < ar_cycle_of[rows[idx+1].master]) begin
      got_first = rows[idx].master;
    end else begin
      got_first = rows[idx+1].master;
    end
    check_value("first_master", got_first, exp_first);
    // Last grant goes to the loser, which then gives up priority
    prio_m1 = exp_first;
  endtask

  task automatic load_table();
    // master, write, addr, len, strb, id, pair
    rows[0] = '{1'b1, 1'b1, 32'h0001_0100, 4'd7, 4'hf, 4'h3, 1'b0};
    rows[1] = '{1'b1, 1'b0, 32'h0001_0100, 4'd7, 4'hf, 4'h5, 1'b0};
    rows[2] = '{1'b1, 1'b1, 32'h0001_0104, 4'd3, 4'h5, 4'h6, 1'b0};
    rows[3] = '{1'b1, 1'b1, 32'h0001_0110, 4'd1, 4'ha, 4'h7, 1'b0};
    rows[4] = '{1'b1, 1'b0, 32'h0001_0100, 4'd7, 4'hf, 4'h8, 1'b0};
    rows[5] = '{1'b1, 1'b1, 32'h0000_0200, 4'd15, 4'hf, 4'h9, 1'b0};
    rows[6] = '{1'b0, 1'b0, 32'h0000_0200, 4'd15, 4'hf, 4'h1, 1'b0};
    // Data memory burst across index 1023
    rows[7] = '{1'b1, 1'b1, 32'h0001_0ff8, 4'd5, 4'hf, 4'h2, 1'b0};
    rows[8] = '{1'b1, 1'b0, 32'h0001_0ff8, 4'd5, 4'hf, 4'h4, 1'b0};
    rows[9] = '{1'b0, 1'b0, 32'h0000_0220, 4'd3, 4'hf, 4'h2, 1'b1};
    rows[10] = '{1'b1, 1'b0, 32'h0001_0100, 4'd3, 4'hf, 4'ha, 1'b0};
    rows[11] = '{1'b0, 1'b0, 32'h0000_0200, 4'd1, 4'hf, 4'h3, 1'b0};
    rows[12] = '{1'b0, 1'b0, 32'h0000_0204, 4'd2, 4'hf, 4'h4, 1'b1};
    rows[13] = '{1'b1, 1'b0, 32'h0001_0ffc, 4'd2, 4'hf, 4'hb, 1'b0};
    rows[14] = '{1'b1, 1'b1, 32'h0000_0ff8, 4'd3, 4'hf, 4'hc, 1'b0};
    rows[15] = '{1'b1, 1'b1, 32'h0000_0ff8, 4'd1, 4'h3, 4'hd, 1'b0};
    rows[16] = '{1'b1, 1'b0, 32'h0001_0110, 4'd0, 4'hf, 4'hf, 1'b0};
    // Both masters on the instruction memory
    rows[17] = '{1'b0, 1'b0, 32'h0000_0ff8, 4'd3, 4'hf, 4'h5, 1'b1};
    rows[18] = '{1'b1, 1'b0, 32'h0000_0ffc, 4'd2, 4'hf, 4'he, 1'b0};
    rows[19] = '{1'b0, 1'b0, 32'h0000_0000, 4'd0, 4'hf, 4'h6, 1'b0};
  endtask

  initial begin
    repeat (reset_cycles + num_rows * 40) @(posedge clk);
    $display("Timeout: the tests did not finish in the allowed number of cycles");
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired");
  end

  initial begin
    load_table();
    lcg_state[0] = 32'd99;
    lcg_state[1] = 32'd99;
    prio_m1 = 1'b0;
    arst_n = 1'b0;
    {ar_id_m0, ar_addr_m0, ar_len_m0, ar_size_m0, ar_burst_m0, ar_valid_m0, r_ready_m0} = '0;
    {ar_id_m1, ar_addr_m1, ar_len_m1, ar_size_m1, ar_burst_m1, ar_valid_m1, r_ready_m1} = '0;
    {aw_id_m1, aw_addr_m1, aw_len_m1, aw_size_m1, aw_burst_m1, aw_valid_m1} = '0;
    {w_data_m1, w_strb_m1, w_last_m1, w_valid_m1, b_ready_m1} = '0;
    repeat (reset_cycles) @(negedge clk);
    arst_n = 1'b1;
    repeat (3) @(negedge clk);
    #1;
    idle_outputs_low();
    r = 0;
    while (r < num_rows) begin
      if (rows[r].pair) begin
        read_collision(r);
        r += 2;
      end else if (rows[r].write) begin
        write_burst(rows[r]);
        r++;
      end else begin
        read_burst(rows[r]);
        prio_m1 = !rows[r].master;
        r++;
      end
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic clk
);

  // 10 ns period
  localparam real half_period = 5.0;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== rtl/axi_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top (
  input  logic clk,
  input  logic arst_n,
  // Master 0, instruction fetch
  input  logic [axi_pkg::axi_id_bits-1:0] ar_id_m0,
  input  logic [axi_pkg::axi_addr_bits-1:0] ar_addr_m0,
  input  logic [axi_pkg::axi_len_bits-1:0] ar_len_m0,
  input  logic [axi_pkg::axi_size_bits-1:0] ar_size_m0,
  input  logic [1:0] ar_burst_m0,
  input  logic ar_valid_m0, r_ready_m0,
  output logic ar_ready_m0, r_last_m0, r_valid_m0,
  output logic [axi_pkg::axi_id_bits-1:0] r_id_m0,
  output logic [axi_pkg::axi_data_bits-1:0] r_data_m0,
  output logic [1:0] r_resp_m0,
  // Master 1, data port
  input  logic [axi_pkg::axi_id_bits-1:0] ar_id_m1, aw_id_m1,
  input  logic [axi_pkg::axi_addr_bits-1:0] ar_addr_m1, aw_addr_m1,
  input  logic [axi_pkg::axi_len_bits-1:0] ar_len_m1, aw_len_m1,
  input  logic [axi_pkg::axi_size_bits-1:0] ar_size_m1, aw_size_m1,
  input  logic [1:0] ar_burst_m1, aw_burst_m1,
  input  logic [axi_pkg::axi_data_bits-1:0] w_data_m1,
  input  logic [axi_pkg::axi_strb_bits-1:0] w_strb_m1,
  input  logic ar_valid_m1, r_ready_m1, aw_valid_m1, w_last_m1, w_valid_m1, b_ready_m1,
  output logic ar_ready_m1, r_last_m1, r_valid_m1, aw_ready_m1, w_ready_m1, b_valid_m1,
  output logic [axi_pkg::axi_id_bits-1:0] r_id_m1, b_id_m1,
  output logic [axi_pkg::axi_data_bits-1:0] r_data_m1,
  output logic [1:0] r_resp_m1, b_resp_m1
);

  import axi_pkg::*;

  logic rst_n_sync;

  // Instruction memory side
  logic [axi_ids_bits-1:0] aw_id_s0, ar_id_s0, b_id_s0, r_id_s0;
  logic [axi_addr_bits-1:0] aw_addr_s0, ar_addr_s0;
  logic [axi_len_bits-1:0] aw_len_s0, ar_len_s0;
  logic [axi_size_bits-1:0] aw_size_s0, ar_size_s0;
  logic [1:0] aw_burst_s0, ar_burst_s0, b_resp_s0, r_resp_s0;
  logic [axi_data_bits-1:0] w_data_s0, r_data_s0;
  logic [axi_strb_bits-1:0] w_strb_s0;
  logic aw_valid_s0, w_last_s0, w_valid_s0, b_ready_s0, ar_valid_s0, r_ready_s0;
  logic aw_ready_s0, w_ready_s0, b_valid_s0, ar_ready_s0, r_last_s0, r_valid_s0;

  // Data memory side
  logic [axi_ids_bits-1:0] aw_id_s1, ar_id_s1, b_id_s1, r_id_s1;
  logic [axi_addr_bits-1:0] aw_addr_s1, ar_addr_s1;
  logic [axi_len_bits-1:0] aw_len_s1, ar_len_s1;
  logic [axi_size_bits-1:0] aw_size_s1, ar_size_s1;
  logic [1:0] aw_burst_s1, ar_burst_s1, b_resp_s1, r_resp_s1;
  logic [axi_data_bits-1:0] w_data_s1, r_data_s1;
  logic [axi_strb_bits-1:0] w_strb_s1;
  logic aw_valid_s1, w_last_s1, w_valid_s1, b_ready_s1, ar_valid_s1, r_ready_s1;
  logic aw_ready_s1, w_ready_s1, b_valid_s1, ar_ready_s1, r_last_s1, r_valid_s1;

  reset_sync u_reset_sync (
    .clk(clk),
    .arst_n(arst_n),
    .rst_n_sync(rst_n_sync)
  );

  axi_bus u_axi_bus (
    .rst_n(rst_n_sync),
    .*
  );

  sram_wrapper u_imem (
    .clk(clk), .rst_n(rst_n_sync),
    .aw_id(aw_id_s0), .aw_addr(aw_addr_s0), .aw_len(aw_len_s0), .aw_size(aw_size_s0),
    .aw_burst(aw_burst_s0), .aw_valid(aw_valid_s0), .aw_ready(aw_ready_s0),
    .w_data(w_data_s0), .w_strb(w_strb_s0), .w_last(w_last_s0),
    .w_valid(w_valid_s0), .w_ready(w_ready_s0),
    .b_id(b_id_s0), .b_resp(b_resp_s0), .b_valid(b_valid_s0), .b_ready(b_ready_s0),
    .ar_id(ar_id_s0), .ar_addr(ar_addr_s0), .ar_len(ar_len_s0), .ar_size(ar_size_s0),
    .ar_burst(ar_burst_s0), .ar_valid(ar_valid_s0), .ar_ready(ar_ready_s0),
    .r_id(r_id_s0), .r_data(r_data_s0), .r_resp(r_resp_s0), .r_last(r_last_s0),
    .r_valid(r_valid_s0), .r_ready(r_ready_s0)
  );

  sram_wrapper u_dmem (
    .clk(clk), .rst_n(rst_n_sync),
    .aw_id(aw_id_s1), .aw_addr(aw_addr_s1), .aw_len(aw_len_s1), .aw_size(aw_size_s1),
    .aw_burst(aw_burst_s1), .aw_valid(aw_valid_s1), .aw_ready(aw_ready_s1),
    .w_data(w_data_s1), .w_strb(w_strb_s1), .w_last(w_last_s1),
    .w_valid(w_valid_s1), .w_ready(w_ready_s1),
    .b_id(b_id_s1), .b_resp(b_resp_s1), .b_valid(b_valid_s1), .b_ready(b_ready_s1),
    .ar_id(ar_id_s1), .ar_addr(ar_addr_s1), .ar_len(ar_len_s1), .ar_size(ar_size_s1),
    .ar_burst(ar_burst_s1), .ar_valid(ar_valid_s1), .ar_ready(ar_ready_s1),
    .r_id(r_id_s1), .r_data(r_data_s1), .r_resp(r_resp_s1), .r_last(r_last_s1),
    .r_valid(r_valid_s1), .r_ready(r_ready_s1)
  );

endmodule

`default_nettype wire

// ==== rtl/axi_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_bus (
  input  logic clk,
  input  logic rst_n,
  // Master 0, read only
  input  logic [axi_pkg::axi_id_bits-1:0] ar_id_m0,
  input  logic [axi_pkg::axi_addr_bits-1:0] ar_addr_m0,
  input  logic [axi_pkg::axi_len_bits-1:0] ar_len_m0,
  input  logic [axi_pkg::axi_size_bits-1:0] ar_size_m0,
  input  logic [1:0] ar_burst_m0,
  input  logic ar_valid_m0, r_ready_m0,
  output logic ar_ready_m0, r_last_m0, r_valid_m0,
  output logic [axi_pkg::axi_id_bits-1:0] r_id_m0,
  output logic [axi_pkg::axi_data_bits-1:0] r_data_m0,
  output logic [1:0] r_resp_m0,
  // Master 1
  input  logic [axi_pkg::axi_id_bits-1:0] ar_id_m1, aw_id_m1,
  input  logic [axi_pkg::axi_addr_bits-1:0] ar_addr_m1, aw_addr_m1,
  input  logic [axi_pkg::axi_len_bits-1:0] ar_len_m1, aw_len_m1,
  input  logic [axi_pkg::axi_size_bits-1:0] ar_size_m1, aw_size_m1,
  input  logic [1:0] ar_burst_m1, aw_burst_m1,
  input  logic [axi_pkg::axi_data_bits-1:0] w_data_m1,
  input  logic [axi_pkg::axi_strb_bits-1:0] w_strb_m1,
  input  logic ar_valid_m1, r_ready_m1, aw_valid_m1, w_last_m1, w_valid_m1, b_ready_m1,
  output logic ar_ready_m1, r_last_m1, r_valid_m1, aw_ready_m1, w_ready_m1, b_valid_m1,
  output logic [axi_pkg::axi_id_bits-1:0] r_id_m1, b_id_m1,
  output logic [axi_pkg::axi_data_bits-1:0] r_data_m1,
  output logic [1:0] r_resp_m1, b_resp_m1,
  // Slave 0, instruction memory
  output logic [axi_pkg::axi_ids_bits-1:0] aw_id_s0, ar_id_s0,
  output logic [axi_pkg::axi_addr_bits-1:0] aw_addr_s0, ar_addr_s0,
  output logic [axi_pkg::axi_len_bits-1:0] aw_len_s0, ar_len_s0,
  output logic [axi_pkg::axi_size_bits-1:0] aw_size_s0, ar_size_s0,
  output logic [1:0] aw_burst_s0, ar_burst_s0,
  output logic [axi_pkg::axi_data_bits-1:0] w_data_s0,
  output logic [axi_pkg::axi_strb_bits-1:0] w_strb_s0,
  output logic aw_valid_s0, w_last_s0, w_valid_s0, b_ready_s0, ar_valid_s0, r_ready_s0,
  input  logic aw_ready_s0, w_ready_s0, b_valid_s0, ar_ready_s0, r_last_s0, r_valid_s0,
  input  logic [axi_pkg::axi_ids_bits-1:0] b_id_s0, r_id_s0,
  input  logic [1:0] b_resp_s0, r_resp_s0,
  input  logic [axi_pkg::axi_data_bits-1:0] r_data_s0,
  // Slave 1, data memory
  output logic [axi_pkg::axi_ids_bits-1:0] aw_id_s1, ar_id_s1,
  output logic [axi_pkg::axi_addr_bits-1:0] aw_addr_s1, ar_addr_s1,
  output logic [axi_pkg::axi_len_bits-1:0] aw_len_s1, ar_len_s1,
  output logic [axi_pkg::axi_size_bits-1:0] aw_size_s1, ar_size_s1,
  output logic [1:0] aw_burst_s1, ar_burst_s1,
  output logic [axi_pkg::axi_data_bits-1:0] w_data_s1,
  output logic [axi_pkg::axi_strb_bits-1:0] w_strb_s1,
  output logic aw_valid_s1, w_last_s1, w_valid_s1, b_ready_s1, ar_valid_s1, r_ready_s1,
  input  logic aw_ready_s1, w_ready_s1, b_valid_s1, ar_ready_s1, r_last_s1, r_valid_s1,
  input  logic [axi_pkg::axi_ids_bits-1:0] b_id_s1, r_id_s1,
  input  logic [1:0] b_resp_s1, r_resp_s1,
  input  logic [axi_pkg::axi_data_bits-1:0] r_data_s1
);

  import axi_pkg::*;

  logic [1:0] grant;
  logic busy, ar_hs, r_last_hs, aw_hs;
  logic ar_valid_g, ar_ready_g, ar_to_s1, rd_sel_s1;
  logic r_valid_g, r_ready_g, r_last_g;
  logic wr_busy, wr_sel_s1, wr_to_s1, aw_go, w_go, b_go;
  logic [axi_ids_bits-1:0] ar_id_g, aw_id_g, r_id_g, b_id_g;
  logic [axi_addr_bits-1:0] ar_addr_g;
  logic [axi_len_bits-1:0] ar_len_g;
  logic [axi_size_bits-1:0] ar_size_g;
  logic [1:0] ar_burst_g, r_resp_g;
  logic [axi_data_bits-1:0] r_data_g;

  read_arbiter u_read_arbiter (
    .clk(clk), .rst_n(rst_n), .ar_valid_m0(ar_valid_m0), .ar_valid_m1(ar_valid_m1),
    .ar_hs(ar_hs), .r_last_hs(r_last_hs), .grant(grant), .busy(busy)
  );

  // AR of the granted master, held off once its address is taken
  assign ar_id_g = grant[1] ? {{(axi_ids_bits-axi_id_bits-1){1'b0}}, 1'b1, ar_id_m1}
                            : {{(axi_ids_bits-axi_id_bits-1){1'b0}}, 1'b0, ar_id_m0};
  assign ar_addr_g = grant[1] ? ar_addr_m1 : ar_addr_m0;
  assign ar_len_g = grant[1] ? ar_len_m1 : ar_len_m0;
  assign ar_size_g = grant[1] ? ar_size_m1 : ar_size_m0;
  assign ar_burst_g = grant[1] ? ar_burst_m1 : ar_burst_m0;
  assign ar_valid_g = !busy && ((grant[0] && ar_valid_m0) || (grant[1] && ar_valid_m1));
  assign ar_to_s1 = ar_addr_g[slave_sel_bit];
  assign ar_ready_g = ar_to_s1 ? ar_ready_s1 : ar_ready_s0;
  assign ar_hs = ar_valid_g && ar_ready_g;
  assign ar_ready_m0 = grant[0] && ar_valid_g && ar_ready_g;
  assign ar_ready_m1 = grant[1] && ar_valid_g && ar_ready_g;

  assign {ar_id_s0, ar_addr_s0, ar_len_s0, ar_size_s0, ar_burst_s0} =
      {ar_id_g, ar_addr_g, ar_len_g, ar_size_g, ar_burst_g};
  assign {ar_id_s1, ar_addr_s1, ar_len_s1, ar_size_s1, ar_burst_s1} =
      {ar_id_g, ar_addr_g, ar_len_g, ar_size_g, ar_burst_g};
  assign ar_valid_s0 = ar_valid_g && !ar_to_s1;
  assign ar_valid_s1 = ar_valid_g && ar_to_s1;

  // R back from the slave that took the address
  assign r_valid_g = rd_sel_s1 ? r_valid_s1 : r_valid_s0;
  assign r_last_g = rd_sel_s1 ? r_last_s1 : r_last_s0;
  assign r_id_g = rd_sel_s1 ? r_id_s1 : r_id_s0;
  assign r_data_g = rd_sel_s1 ? r_data_s1 : r_data_s0;
  assign r_resp_g = rd_sel_s1 ? r_resp_s1 : r_resp_s0;
  assign r_ready_g = grant[1] ? r_ready_m1 : r_ready_m0;
  assign r_ready_s0 = busy && !rd_sel_s1 && r_ready_g;
  assign r_ready_s1 = busy && rd_sel_s1 && r_ready_g;
  assign r_last_hs = busy && r_valid_g && r_ready_g && r_last_g;

  assign r_valid_m0 = busy && grant[0] && r_valid_g;
  assign r_valid_m1 = busy && grant[1] && r_valid_g;
  assign r_last_m0 = r_last_g;
  assign r_last_m1 = r_last_g;
  assign r_id_m0 = r_id_g[axi_id_bits-1:0];
  assign r_id_m1 = r_id_g[axi_id_bits-1:0];
  assign r_data_m0 = r_data_g;
  assign r_data_m1 = r_data_g;
  assign r_resp_m0 = r_resp_g;
  assign r_resp_m1 = r_resp_g;

  // Writes come from master 1 only
  assign aw_id_g = {{(axi_ids_bits-axi_id_bits-1){1'b0}}, 1'b1, aw_id_m1};
  assign wr_to_s1 = wr_busy ? wr_sel_s1 : aw_addr_m1[slave_sel_bit];
  assign aw_go = aw_valid_m1 && !wr_busy;
  assign w_go = w_valid_m1 && wr_busy;
  assign b_go = b_ready_m1 && wr_busy;
  assign aw_ready_m1 = aw_go && (wr_to_s1 ? aw_ready_s1 : aw_ready_s0);
  assign aw_hs = aw_go && aw_ready_m1;
  assign w_ready_m1 = wr_busy && (wr_sel_s1 ? w_ready_s1 : w_ready_s0);
  assign b_valid_m1 = wr_busy && (wr_sel_s1 ? b_valid_s1 : b_valid_s0);
  assign b_id_g = wr_sel_s1 ? b_id_s1 : b_id_s0;
  assign b_id_m1 = b_id_g[axi_id_bits-1:0];
  assign b_resp_m1 = wr_sel_s1 ? b_resp_s1 : b_resp_s0;

  // Slave not being written sees all zeros
  assign {aw_id_s0, aw_addr_s0, aw_len_s0, aw_size_s0, aw_burst_s0, aw_valid_s0,
          w_data_s0, w_strb_s0, w_last_s0, w_valid_s0, b_ready_s0} =
      wr_to_s1 ? '0 : {aw_id_g, aw_addr_m1, aw_len_m1, aw_size_m1, aw_burst_m1, aw_go,
                       w_data_m1, w_strb_m1, w_last_m1, w_go, b_go};
  assign {aw_id_s1, aw_addr_s1, aw_len_s1, aw_size_s1, aw_burst_s1, aw_valid_s1,
          w_data_s1, w_strb_s1, w_last_s1, w_valid_s1, b_ready_s1} =
      wr_to_s1 ? {aw_id_g, aw_addr_m1, aw_len_m1, aw_size_m1, aw_burst_m1, aw_go,
                  w_data_m1, w_strb_m1, w_last_m1, w_go, b_go} : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_sel_s1 <= 1'b0;
      wr_busy <= 1'b0;
      wr_sel_s1 <= 1'b0;
    end else begin
      if (ar_hs) begin
        rd_sel_s1 <= ar_to_s1;
      end
      if (aw_hs) begin
        wr_busy <= 1'b1;
        wr_sel_s1 <= wr_to_s1;
      end else if (b_valid_m1 && b_ready_m1) begin
        wr_busy <= 1'b0;
      end
    end
  end

  // Master index carried through the slave comes back with the data
  a_r_owner: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid_g && busy |-> (r_id_g[axi_id_bits] == grant[1]));

endmodule

`default_nettype wire

// ==== rtl/sram_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_wrapper (
  input  logic clk,
  input  logic rst_n,
  input  logic [axi_pkg::axi_ids_bits-1:0] aw_id, ar_id,
  input  logic [axi_pkg::axi_addr_bits-1:0] aw_addr, ar_addr,
  input  logic [axi_pkg::axi_len_bits-1:0] aw_len, ar_len,
  input  logic [axi_pkg::axi_size_bits-1:0] aw_size, ar_size,
  input  logic [1:0] aw_burst, ar_burst,
  input  logic [axi_pkg::axi_data_bits-1:0] w_data,
  input  logic [axi_pkg::axi_strb_bits-1:0] w_strb,
  input  logic aw_valid, w_last, w_valid, b_ready, ar_valid, r_ready,
  output logic aw_ready, w_ready, b_valid, ar_ready, r_last, r_valid,
  output logic [axi_pkg::axi_ids_bits-1:0] b_id, r_id,
  output logic [1:0] b_resp, r_resp,
  output logic [axi_pkg::axi_data_bits-1:0] r_data
);

  import axi_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_write,
    st_resp
  } slv_state_t;

  slv_state_t state;
  logic [axi_ids_bits-1:0] id_q;
  logic [axi_data_bits-1:0] mem [sram_words];
  logic [sram_index_bits-1:0] rd_index;
  logic [sram_index_bits-1:0] wr_index;
  logic [sram_index_bits-1:0] rd_addr;
  logic rd_last, rd_active, wr_last, wr_active, rd_en;
  logic ar_hs, aw_hs, w_hs, r_hs, b_hs;

  assign ar_ready = (state == st_idle);
  // A read wins a tie with a write
  assign aw_ready = (state == st_idle) && !ar_valid;
  assign r_valid = rd_active;
  assign w_ready = wr_active;
  assign b_valid = (state == st_resp);
  assign r_last = rd_active && rd_last;
  assign r_id = id_q;
  assign b_id = id_q;
  assign r_resp = resp_okay;
  assign b_resp = resp_okay;

  assign ar_hs = ar_valid && ar_ready;
  assign aw_hs = aw_valid && aw_ready;
  assign w_hs = w_valid && w_ready;
  assign r_hs = r_valid && r_ready;
  assign b_hs = b_valid && b_ready;

  burst_counter u_rd_cnt (
    .clk(clk), .rst_n(rst_n), .load(ar_hs),
    .start_index(ar_addr[index_lsb +: sram_index_bits]), .len(ar_len),
    .step(r_hs), .index(rd_index), .last(rd_last), .active(rd_active)
  );

  burst_counter u_wr_cnt (
    .clk(clk), .rst_n(rst_n), .load(aw_hs),
    .start_index(aw_addr[index_lsb +: sram_index_bits]), .len(aw_len),
    .step(w_hs), .index(wr_index), .last(wr_last), .active(wr_active)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (ar_hs) begin
            state <= st_read;
          end else if (aw_hs) begin
            state <= st_write;
          end
        end
        st_read: if (r_hs && rd_last) state <= st_idle;
        st_write: if (w_hs && w_last) state <= st_resp;
        st_resp: if (b_hs) state <= st_idle;
        default: state <= st_idle;
      endcase
    end
  end

  // Next word is fetched on the handshake of the current one
  assign rd_addr = ar_hs ? ar_addr[index_lsb +: sram_index_bits] : rd_index + 1'b1;
  assign rd_en = ar_hs || (r_hs && !rd_last);

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      id_q <= ar_id;
    end else if (aw_hs) begin
      id_q <= aw_id;
    end
    if (w_hs) begin
      for (int b = 0; b < axi_strb_bits; b++) begin
        if (w_strb[b]) begin
          mem[wr_index][8*b +: 8] <= w_data[8*b +: 8];
        end
      end
    end
    if (rd_en) begin
      r_data <= mem[rd_addr];
    end
  end

  a_ar_incr_word: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> (ar_burst == burst_incr && ar_size == size_word));
  a_aw_incr_word: assert property (@(posedge clk) disable iff (!rst_n)
    aw_hs |-> (aw_burst == burst_incr && aw_size == size_word));
  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (r_valid && !r_ready) |=> (r_valid && $stable(r_data)));
  // Master's w_last lines up with the beat count from aw_len
  a_w_last_len: assert property (@(posedge clk) disable iff (!rst_n)
    w_hs |-> (w_last == wr_last));

endmodule

`default_nettype wire

// ==== rtl/burst_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_counter (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                load,
  input  logic [axi_pkg::sram_index_bits-1:0] start_index,
  input  logic [axi_pkg::axi_len_bits-1:0]    len,
  input  logic                                step,
  output logic [axi_pkg::sram_index_bits-1:0] index,
  output logic                                last,
  output logic                                active
);

  import axi_pkg::*;

  logic [axi_len_bits-1:0] remaining;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      index <= '0;
      remaining <= '0;
      active <= 1'b0;
    end else if (load) begin
      index <= start_index;
      remaining <= len;
      active <= 1'b1;
    end else if (step) begin
      // Index wraps within the array
      index <= index + 1'b1;
      if (remaining == '0) begin
        active <= 1'b0;
      end else begin
        remaining <= remaining - 1'b1;
      end
    end
  end

  assign last = active && (remaining == '0);

  a_step_active: assert property (@(posedge clk) disable iff (!rst_n) step |-> active);

endmodule

`default_nettype wire

// ==== rtl/read_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module read_arbiter (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ar_valid_m0,
  input  logic       ar_valid_m1,
  input  logic       ar_hs,
  input  logic       r_last_hs,
  output logic [1:0] grant,
  output logic       busy
);

  typedef enum logic [1:0] {
    st_idle,
    st_m0,
    st_m1
  } arb_state_t;

  arb_state_t state;
  logic prio_m1;
  logic addr_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      prio_m1 <= 1'b0;
      addr_done <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          // Priority moves to the other master on every grant
          if (ar_valid_m0 && (!ar_valid_m1 || !prio_m1)) begin
            state <= st_m0;
            prio_m1 <= 1'b1;
          end else if (ar_valid_m1) begin
            state <= st_m1;
            prio_m1 <= 1'b0;
          end
        end
        default: begin
          if (ar_hs) begin
            addr_done <= 1'b1;
          end
          if (r_last_hs) begin
            state <= st_idle;
            addr_done <= 1'b0;
          end
        end
      endcase
    end
  end

  assign grant = {state == st_m1, state == st_m0};

  // Address taken, burst still running
  assign busy = addr_done;

  // A granted master keeps ar_valid up until its address is taken
  a_grant_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    (grant != 2'b00 && !busy) |-> (grant[0] ? ar_valid_m0 : ar_valid_m1));

endmodule

`default_nettype wire

// ==== rtl/reset_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_sync (
  input  logic clk,
  input  logic arst_n,
  output logic rst_n_sync
);

  logic stage1;

  // Assert at once, release after two edges
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      stage1 <= 1'b0;
      rst_n_sync <= 1'b0;
    end else begin
      stage1 <= 1'b1;
      rst_n_sync <= stage1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

  localparam int axi_id_bits = 4;
  // Master ID in the low bits, master index just above
  localparam int axi_ids_bits = 8;
  localparam int axi_addr_bits = 32;
  localparam int axi_data_bits = 32;
  localparam int axi_strb_bits = 4;
  localparam int axi_len_bits = 4;
  localparam int axi_size_bits = 3;

  localparam logic [2:0] size_word = 3'b010;
  localparam logic [1:0] burst_incr = 2'b01;
  localparam logic [1:0] resp_okay = 2'b00;

  // Address map
  localparam int slave_sel_bit = 16;
  localparam int sram_words = 1024;
  localparam int sram_index_bits = 10;
  localparam int index_lsb = 2;

endpackage

`default_nettype wire
